/* hw/bypassIf.sv */
`timescale 1ns/1ps

interface bypassIf;

    // Memory stage result
    logic        memRegWrite;
    logic [4:0]  memRd;
    logic [31:0] memResult;

    // Writeback stage result, also the register file write
    logic        wbRegWrite;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    modport retire (output memRegWrite, memRd, memResult, wbRegWrite, wbRd, wbData);

    modport exec (input memRegWrite, memRd, memResult, wbRegWrite, wbRd, wbData);

    modport regs (input wbRegWrite, wbRd, wbData);

endinterface

/* hw/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit import mipsPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       writeEx_i,
    input  logic       flushEx_i,
    input  instU       idInst_i,
    input  dataT       idPcPlus4_i,
    input  dataT       rsData_i,
    input  dataT       rtData_i,
    output regAddrT    rsAddr_o,
    output regAddrT    rtAddr_o,
    output logic       exRegWrite_o,
    output logic       exBeq_o,
    output logic       exBne_o,
    output logic       exJump_o,
    output logic       exAluSrcImm_o,
    output aluOpE      exAluOp_o,
    output regAddrT    exRs_o,
    output regAddrT    exRt_o,
    output regAddrT    exRd_o,
    output dataT       exRsData_o,
    output dataT       exRtData_o,
    output dataT       exImm_o,
    output dataT       exPcPlus4_o,
    output logic [4:0] exShamt_o
);

    logic    regWrite;
    logic    beq;
    logic    bne;
    logic    jump;
    logic    aluSrcImm;
    aluOpE   aluOp;
    regAddrT rd;
    dataT    imm;

    assign rsAddr_o = idInst_i.rType.rs;
    assign rtAddr_o = idInst_i.rType.rt;

    always_comb begin
        regWrite  = 1'b0;
        beq       = 1'b0;
        bne       = 1'b0;
        jump      = 1'b0;
        aluSrcImm = 1'b0;
        aluOp     = AluAdd;
        case (idInst_i.rType.opcode)
            OpRType: begin
                regWrite = 1'b1;
                case (idInst_i.rType.funct)
                    FnSll:   aluOp = AluSll;
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnSlt:   aluOp = AluSlt;
                    default: regWrite = 1'b0;
                endcase
            end
            OpAddiu: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            OpBeq:   beq = 1'b1;
            OpBne:   bne = 1'b1;
            OpJ:     jump = 1'b1;
            // Anything else retires as a no-op
            default: regWrite = 1'b0;
        endcase
    end

    assign rd = aluSrcImm ? idInst_i.iType.rt : idInst_i.rType.rd;

    // Jump target is fully formed here, branches keep the sign-extended offset
    assign imm = jump ? {idPcPlus4_i[31:28], idInst_i.jType.target26, 2'b00}
                      : {{(DataWidth-16){idInst_i.iType.imm16[15]}}, idInst_i.iType.imm16};

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst || flushEx_i) begin
            exRegWrite_o  <= 1'b0;
            exBeq_o       <= 1'b0;
            exBne_o       <= 1'b0;
            exJump_o      <= 1'b0;
            exAluSrcImm_o <= 1'b0;
            exAluOp_o     <= AluAdd;
            exRs_o        <= '0;
            exRt_o        <= '0;
            exRd_o        <= '0;
            exRsData_o    <= '0;
            exRtData_o    <= '0;
            exImm_o       <= '0;
            exPcPlus4_o   <= '0;
            exShamt_o     <= '0;
        end else if (writeEx_i) begin
            exRegWrite_o  <= regWrite;
            exBeq_o       <= beq;
            exBne_o       <= bne;
            exJump_o      <= jump;
            exAluSrcImm_o <= aluSrcImm;
            exAluOp_o     <= aluOp;
            exRs_o        <= idInst_i.rType.rs;
            exRt_o        <= idInst_i.rType.rt;
            exRd_o        <= rd;
            exRsData_o    <= rsData_i;
            exRtData_o    <= rtData_i;
            exImm_o       <= imm;
            exPcPlus4_o   <= idPcPlus4_i;
            exShamt_o     <= idInst_i.rType.shamt;
        end
    end

endmodule

/* hw/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       writeMem_i,
    input  logic       exRegWrite_i,
    input  logic       exBeq_i,
    input  logic       exBne_i,
    input  logic       exJump_i,
    input  logic       exAluSrcImm_i,
    input  aluOpE      exAluOp_i,
    input  regAddrT    exRs_i,
    input  regAddrT    exRt_i,
    input  regAddrT    exRd_i,
    input  dataT       exRsData_i,
    input  dataT       exRtData_i,
    input  dataT       exImm_i,
    input  dataT       exPcPlus4_i,
    input  logic [4:0] exShamt_i,
    bypassIf.exec      bypass,
    output logic       redirect_o,
    output dataT       redirectPc_o,
    output logic       memRegWrite_o,
    output regAddrT    memRd_o,
    output dataT       memResult_o
);

    fwdSelE fwdA;
    fwdSelE fwdB;
    dataT   opA;
    dataT   opB;
    dataT   aluB;
    dataT   aluRes;
    logic   equal;

    // Youngest producer wins, r0 is never forwarded
    function automatic fwdSelE pickSource(input regAddrT src, input logic memWr,
                                          input regAddrT memRd, input logic wbWr,
                                          input regAddrT wbRd);
        if (memWr && memRd != '0 && memRd == src) begin
            return FwdMem;
        end else if (wbWr && wbRd != '0 && wbRd == src) begin
            return FwdWb;
        end
        return FwdReg;
    endfunction

    function automatic dataT fwdMux(input fwdSelE sel, input dataT regVal,
                                    input dataT memVal, input dataT wbVal);
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign fwdA = pickSource(exRs_i, bypass.memRegWrite, bypass.memRd,
                             bypass.wbRegWrite, bypass.wbRd);
    assign fwdB = pickSource(exRt_i, bypass.memRegWrite, bypass.memRd,
                             bypass.wbRegWrite, bypass.wbRd);

    assign opA  = fwdMux(fwdA, exRsData_i, bypass.memResult, bypass.wbData);
    assign opB  = fwdMux(fwdB, exRtData_i, bypass.memResult, bypass.wbData);
    assign aluB = exAluSrcImm_i ? exImm_i : opB;

    always_comb begin
        case (exAluOp_i)
            AluAdd:  aluRes = opA + aluB;
            AluSub:  aluRes = opA - aluB;
            AluAnd:  aluRes = opA & aluB;
            AluOr:   aluRes = opA | aluB;
            AluSlt:  aluRes = {{(DataWidth-1){1'b0}}, $signed(opA) < $signed(aluB)};
            AluSll:  aluRes = opB << exShamt_i;
            default: aluRes = '0;
        endcase
    end

    assign equal        = (opA == opB);
    assign redirect_o   = exJump_i || (exBeq_i && equal) || (exBne_i && !equal);
    assign redirectPc_o = exJump_i ? exImm_i
                                   : exPcPlus4_i + {exImm_i[DataWidth-3:0], 2'b00};

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            memRegWrite_o <= 1'b0;
            memRd_o       <= '0;
            memResult_o   <= '0;
        end else if (writeMem_i) begin
            memRegWrite_o <= exRegWrite_i;
            memRd_o       <= exRd_i;
            memResult_o   <= aluRes;
        end
    end

    fwdKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown({opA, opB}));

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 writePc_i,
    input  logic                 writeId_i,
    input  logic                 flushId_i,
    input  logic                 redirect_i,
    input  dataT                 redirectPc_i,
    input  instU                 icacheData_i,
    output logic [DataWidth-3:0] icacheAddr_o,
    output instU                 idInst_o,
    output dataT                 idPcPlus4_o
);

    dataT pc;
    dataT pcPlus4;
    dataT nextPc;

    assign pcPlus4      = pc + 'd4;
    assign nextPc       = redirect_i ? redirectPc_i : pcPlus4;
    assign icacheAddr_o = pc[DataWidth-1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (writePc_i) begin
            pc <= nextPc;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (rst || flushId_i) begin
            idInst_o    <= '0;
            idPcPlus4_o <= '0;
        end else if (writeId_i) begin
            idInst_o    <= icacheData_i;
            idPcPlus4_o <= pcPlus4;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 icacheStall_i,
    input  logic [31:0]          icacheData_i,
    output logic [DataWidth-3:0] icacheAddr_o,
    output logic                 wbValid_o,
    output regAddrT              wbReg_o,
    output dataT                 wbData_o
);

    logic       writePc;
    logic       writeId;
    logic       flushId;
    logic       flushEx;
    logic       writeEx;
    logic       writeMem;
    logic       writeWb;
    logic       redirect;
    dataT       redirectPc;
    instU       idInst;
    dataT       idPcPlus4;
    regAddrT    rsAddr;
    regAddrT    rtAddr;
    dataT       rsData;
    dataT       rtData;
    logic       exRegWrite;
    logic       exBeq;
    logic       exBne;
    logic       exJump;
    logic       exAluSrcImm;
    aluOpE      exAluOp;
    regAddrT    exRs;
    regAddrT    exRt;
    regAddrT    exRd;
    dataT       exRsData;
    dataT       exRtData;
    dataT       exImm;
    dataT       exPcPlus4;
    logic [4:0] exShamt;
    logic       memRegWrite;
    regAddrT    memRd;
    dataT       memResult;

    bypassIf bypass0 ();

    pipeControl ctrl0 (
        .stall_i    (icacheStall_i),
        .redirect_i (redirect),
        .writePc_o  (writePc),
        .writeId_o  (writeId),
        .flushId_o  (flushId),
        .flushEx_o  (flushEx),
        .writeEx_o  (writeEx),
        .writeMem_o (writeMem),
        .writeWb_o  (writeWb)
    );

    fetchUnit fetch0 (
        .clk          (clk),
        .rst          (rst),
        .writePc_i    (writePc),
        .writeId_i    (writeId),
        .flushId_i    (flushId),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .icacheData_i (icacheData_i),
        .icacheAddr_o (icacheAddr_o),
        .idInst_o     (idInst),
        .idPcPlus4_o  (idPcPlus4)
    );

    decodeUnit decode0 (
        .clk           (clk),
        .rst           (rst),
        .writeEx_i     (writeEx),
        .flushEx_i     (flushEx),
        .idInst_i      (idInst),
        .idPcPlus4_i   (idPcPlus4),
        .rsData_i      (rsData),
        .rtData_i      (rtData),
        .rsAddr_o      (rsAddr),
        .rtAddr_o      (rtAddr),
        .exRegWrite_o  (exRegWrite),
        .exBeq_o       (exBeq),
        .exBne_o       (exBne),
        .exJump_o      (exJump),
        .exAluSrcImm_o (exAluSrcImm),
        .exAluOp_o     (exAluOp),
        .exRs_o        (exRs),
        .exRt_o        (exRt),
        .exRd_o        (exRd),
        .exRsData_o    (exRsData),
        .exRtData_o    (exRtData),
        .exImm_o       (exImm),
        .exPcPlus4_o   (exPcPlus4),
        .exShamt_o     (exShamt)
    );

    regFile regs0 (
        .clk       (clk),
        .rst       (rst),
        .rsAddr_i  (rsAddr),
        .rtAddr_i  (rtAddr),
        .writeEn_i (writeWb),
        .bypass    (bypass0.regs),
        .rsData_o  (rsData),
        .rtData_o  (rtData)
    );

    executeUnit exec0 (
        .clk           (clk),
        .rst           (rst),
        .writeMem_i    (writeMem),
        .exRegWrite_i  (exRegWrite),
        .exBeq_i       (exBeq),
        .exBne_i       (exBne),
        .exJump_i      (exJump),
        .exAluSrcImm_i (exAluSrcImm),
        .exAluOp_i     (exAluOp),
        .exRs_i        (exRs),
        .exRt_i        (exRt),
        .exRd_i        (exRd),
        .exRsData_i    (exRsData),
        .exRtData_i    (exRtData),
        .exImm_i       (exImm),
        .exPcPlus4_i   (exPcPlus4),
        .exShamt_i     (exShamt),
        .bypass        (bypass0.exec),
        .redirect_o    (redirect),
        .redirectPc_o  (redirectPc),
        .memRegWrite_o (memRegWrite),
        .memRd_o       (memRd),
        .memResult_o   (memResult)
    );

    retireStage retire0 (
        .clk           (clk),
        .rst           (rst),
        .writeWb_i     (writeWb),
        .memRegWrite_i (memRegWrite),
        .memRd_i       (memRd),
        .memResult_i   (memResult),
        .bypass        (bypass0.retire),
        .wbValid_o     (wbValid_o),
        .wbReg_o       (wbReg_o),
        .wbData_o      (wbData_o)
    );

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    typedef logic [DataWidth-1:0]    dataT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpJ     = 6'h02;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;
    localparam logic [5:0] OpAddiu = 6'h09;

    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluSll} aluOpE;

    typedef enum logic [1:0] {FwdReg, FwdMem, FwdWb} fwdSelE;

    // Three views of one instruction word
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regAddrT    rs;
            regAddrT    rt;
            regAddrT    rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            regAddrT     rs;
            regAddrT     rt;
            logic [15:0] imm16;
        } iType;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } jType;
    } instU;

endpackage

/* hw/pipeControl.sv */
`timescale 1ns/1ps

module pipeControl (
    input  logic stall_i,
    input  logic redirect_i,
    output logic writePc_o,
    output logic writeId_o,
    output logic flushId_o,
    output logic flushEx_o,
    output logic writeEx_o,
    output logic writeMem_o,
    output logic writeWb_o
);

    // Instruction port stall freezes the whole pipe
    assign writePc_o  = !stall_i;
    assign writeId_o  = !stall_i;
    assign writeEx_o  = !stall_i;
    assign writeMem_o = !stall_i;
    assign writeWb_o  = !stall_i;

    // Redirect waits in execute until the stall drops
    assign flushId_o = redirect_i && !stall_i;
    assign flushEx_o = redirect_i && !stall_i;

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT rsAddr_i,
    input  regAddrT rtAddr_i,
    input  logic    writeEn_i,
    bypassIf.regs   bypass,
    output dataT    rsData_o,
    output dataT    rtData_o
);

    // r0 has no storage
    dataT regs [31:1];
    logic doWrite;

    assign doWrite = writeEn_i && bypass.wbRegWrite && (bypass.wbRd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[bypass.wbRd] <= bypass.wbData;
        end
    end

    // Write-through so decode sees a same-cycle writeback
    always_comb begin
        if (rsAddr_i == '0) begin
            rsData_o = '0;
        end else if (doWrite && bypass.wbRd == rsAddr_i) begin
            rsData_o = bypass.wbData;
        end else begin
            rsData_o = regs[rsAddr_i];
        end
    end

    always_comb begin
        if (rtAddr_i == '0) begin
            rtData_o = '0;
        end else if (doWrite && bypass.wbRd == rtAddr_i) begin
            rtData_o = bypass.wbData;
        end else begin
            rtData_o = regs[rtAddr_i];
        end
    end

endmodule

/* hw/retireStage.sv */
`timescale 1ns/1ps

module retireStage import mipsPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    writeWb_i,
    input  logic    memRegWrite_i,
    input  regAddrT memRd_i,
    input  dataT    memResult_i,
    bypassIf.retire bypass,
    output logic    wbValid_o,
    output regAddrT wbReg_o,
    output dataT    wbData_o
);

    logic    wbRegWrite;
    regAddrT wbRd;
    dataT    wbData;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
            wbRd       <= '0;
            wbData     <= '0;
        end else if (writeWb_i) begin
            wbRegWrite <= memRegWrite_i;
            wbRd       <= memRd_i;
            wbData     <= memResult_i;
        end
    end

    assign bypass.memRegWrite = memRegWrite_i;
    assign bypass.memRd       = memRd_i;
    assign bypass.memResult   = memResult_i;
    assign bypass.wbRegWrite  = wbRegWrite;
    assign bypass.wbRd        = wbRd;
    assign bypass.wbData      = wbData;

    // Only in the cycle the write commits, once per instruction
    assign wbValid_o = wbRegWrite && (wbRd != '0) && writeWb_i;
    assign wbReg_o   = wbRd;
    assign wbData_o  = wbData;

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module mipsCoreTb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VmipsCoreTb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF "** PASS **" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* testbench/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*; ();

    localparam int ResetCycles    = 16;
    localparam int TargetWrites   = 400;
    localparam int WbTimeout      = 2000;
    localparam int ModelStepLimit = 4096;

    logic                 clk;
    logic                 rst;
    logic                 icacheStall_i;
    logic [31:0]          icacheData_i;
    logic [DataWidth-3:0] icacheAddr_o;
    logic                 wbValid_o;
    regAddrT              wbReg_o;
    dataT                 wbData_o;

    instU        progMem [0:255];
    logic [31:0] lfsrState;

    // ISA model state
    dataT    mPc;
    dataT    mRegs [0:31];
    regAddrT expReg[$];
    dataT    expData[$];

    int matched;
    int idle;
    int cycle;
    int steps;

    mipsCore dut0 (
        .clk           (clk),
        .rst           (rst),
        .icacheStall_i (icacheStall_i),
        .icacheData_i  (icacheData_i),
        .icacheAddr_o  (icacheAddr_o),
        .wbValid_o     (wbValid_o),
        .wbReg_o       (wbReg_o),
        .wbData_o      (wbData_o)
    );

    always #10 clk = !clk;

    // Instruction memory answers in the same cycle
    assign icacheData_i = progMem[icacheAddr_o[7:0]];

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val       = {val[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return val;
    endfunction

    function automatic instU buildInst(input int idx);
        instU        w;
        logic [3:0]  cls;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic [3:0]  off;
        cls   = 4'(randBits(4));
        w     = '0;
        w.rType.rs = regAddrT'(randBits(3));
        w.rType.rt = regAddrT'(randBits(3));
        w.rType.rd = regAddrT'(randBits(3));
        shamt = 5'(randBits(5));
        imm   = 16'(randBits(16));
        off   = 4'(randBits(3)) + 4'd1;
        w.rType.opcode = OpRType;
        case (cls)
            4'd0, 4'd1: w.rType.funct = FnAddu;
            4'd2:       w.rType.funct = FnSubu;
            4'd3:       w.rType.funct = FnAnd;
            4'd4:       w.rType.funct = FnOr;
            4'd5, 4'd6: w.rType.funct = FnSlt;
            4'd7: begin
                w.rType.funct = FnSll;
                w.rType.shamt = shamt;
            end
            4'd8, 4'd9, 4'd10: begin
                w.iType.opcode = OpAddiu;
                w.iType.imm16  = imm;
            end
            4'd11: begin
                w.iType.opcode = OpBeq;
                w.iType.imm16  = {12'd0, off};
            end
            4'd12: begin
                w.iType.opcode = OpBne;
                w.iType.imm16  = {12'd0, off};
            end
            4'd13: begin
                w.jType.opcode   = OpJ;
                w.jType.target26 = 26'(idx + 1 + int'(off));
            end
            // Undefined opcode, then undefined funct
            4'd14:   w.rType.opcode = 6'h3f;
            default: w.rType.funct = 6'h3f;
        endcase
        return w;
    endfunction

    function automatic dataT readReg(input regAddrT idx);
        return (idx == '0) ? '0 : mRegs[idx];
    endfunction

    task automatic writeReg(input regAddrT idx, input dataT val);
        if (idx != '0) begin
            mRegs[idx] = val;
            expReg.push_back(idx);
            expData.push_back(val);
        end
    endtask

    // Executes one instruction in program order, no delay slot
    task automatic modelStep();
        instU w;
        dataT a;
        dataT b;
        dataT sext;
        dataT nextPc;
        w      = progMem[mPc[9:2]];
        a      = readReg(w.rType.rs);
        b      = readReg(w.rType.rt);
        sext   = {{16{w.iType.imm16[15]}}, w.iType.imm16};
        nextPc = mPc + 32'd4;
        case (w.rType.opcode)
            OpRType: begin
                case (w.rType.funct)
                    FnAddu:  writeReg(w.rType.rd, a + b);
                    FnSubu:  writeReg(w.rType.rd, a - b);
                    FnAnd:   writeReg(w.rType.rd, a & b);
                    FnOr:    writeReg(w.rType.rd, a | b);
                    FnSlt:   writeReg(w.rType.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    FnSll:   writeReg(w.rType.rd, b << w.rType.shamt);
                    default: ;
                endcase
            end
            OpAddiu: writeReg(w.iType.rt, a + sext);
            OpBeq: begin
                if (a == b) begin
                    nextPc = nextPc + (sext << 2);
                end
            end
            OpBne: begin
                if (a != b) begin
                    nextPc = nextPc + (sext << 2);
                end
            end
            OpJ:     nextPc = {nextPc[31:28], w.jType.target26, 2'b00};
            default: ;
        endcase
        mPc = nextPc;
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        string msg;
        if (got !== exp) begin
            msg = $sformatf("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                            $time, name, got, exp);
            failRun(msg);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        icacheStall_i = 1'b0;
        lfsrState     = 32'h8040_ba50;
        mPc           = '0;
        matched       = 0;
        idle          = 0;
        cycle         = 0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            progMem[i] = buildInst(i);
        end

        for (int i = 0; i < ResetCycles; i++) begin
            @(posedge clk);
            #1;
            checkEq("wbValid_o", 32'(wbValid_o), 32'd0);
        end
        rst = 1'b0;
        checkEq("icacheAddr_o", 32'(icacheAddr_o), 32'd0);

        while (matched < TargetWrites) begin
            @(negedge clk);
            // Nothing can retire before four pipeline advances
            if (cycle < 4) begin
                checkEq("wbValid_o", 32'(wbValid_o), 32'd0);
            end
            if (wbValid_o) begin
                steps = 0;
                while (expData.size() == 0) begin
                    if (steps >= ModelStepLimit) begin
                        failRun("Model ran too long without any register write");
                    end
                    modelStep();
                    steps++;
                end
                checkEq("wbReg_o", 32'(wbReg_o), 32'(expReg[0]));
                checkEq("wbData_o", wbData_o, expData[0]);
                void'(expReg.pop_front());
                void'(expData.pop_front());
                matched++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WbTimeout) begin
                    failRun("Timeout waiting for the next writeback");
                end
            end
            @(posedge clk);
            #1;
            // Stall about one cycle in four
            icacheStall_i = (randBits(2) == 32'd0);
            cycle++;
        end

        $display("** PASS **");
        $finish;
    end

endmodule

/* verilog.f */
hw/mipsPkg.sv
hw/bypassIf.sv
hw/fetchUnit.sv
hw/pipeControl.sv
hw/decodeUnit.sv
hw/regFile.sv
hw/executeUnit.sv
hw/retireStage.sv
hw/mipsCore.sv
testbench/mipsCoreTb.sv
